//--- luma_stim.txt
# columns: opcode then arguments
# START | PIX r g b expected_y | STALL cycles | RAND count | WAIT_DONE
# frame 1, fixed pixels with stalls and an ignored start
START
PIX 0 0 0 0
PIX 255 255 255 255
PIX 255 0 0 77
PIX 0 255 0 149
PIX 0 0 255 29
PIX 128 128 128 128
PIX 64 64 64 64
PIX 200 200 200 200
STALL 5
PIX 100 50 200 82
PIX 10 20 30 18
# start while the frame is open
START
PIX 200 100 50 124
PIX 0 255 255 178
PIX 255 255 0 226
STALL 3
PIX 255 0 255 106
PIX 1 1 1 1
PIX 64 32 16 40
WAIT_DONE
STALL 4
# frame 2, random pixels, start during drain
START
RAND 16
START
WAIT_DONE
STALL 2
# frame 3, greys and mixed colours with stalls
START
PIX 10 10 10 10
PIX 20 20 20 20
PIX 30 30 30 30
STALL 1
PIX 40 40 40 40
PIX 50 50 50 50
PIX 60 60 60 60
STALL 6
PIX 70 70 70 70
PIX 80 80 80 80
PIX 90 90 90 90
PIX 100 100 100 100
STALL 2
PIX 110 110 110 110
PIX 120 120 120 120
PIX 50 60 70 58
PIX 17 33 99 36
STALL 3
PIX 100 50 200 82
PIX 255 255 255 255
WAIT_DONE
# frame 4, random pixels with a start in the middle
START
RAND 8
START
RAND 8
WAIT_DONE
STALL 5

//--- filelist.f
luma_pkg.sv
rgb_term_mul.sv
rgb_sum_acc.sv
pixel_counter.sv
frame_ctrl.sv
luma_conv_top.sv
tb_luma_conv.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the luma converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module tb_luma_conv \
  -o tb_luma_conv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit $status
fi

./obj_dir/tb_luma_conv_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation completed"
exit 0

//--- tb_luma_conv.sv
// testbench for the rgb to luma converter
// runs the opcoded stimulus file, models the frame FSM and checks every luma
`timescale 1ns/10ps
`default_nettype none

module tb_luma_conv import luma_pkg::*; ();

  typedef enum logic [2:0] {START, PIX, STALL, RAND, WAIT_DONE} stim_op_e;

  localparam int MAX_LINES = 256;

  logic  clk;
  logic  rst;
  logic  start;
  logic  pix_valid;
  pix_t  r;
  pix_t  g;
  pix_t  b;
  logic  in_ready;
  logic  out_ready;
  logic  y_valid;
  luma_t y;
  logic  frame_done;

  stim_op_e     ops [0:MAX_LINES-1];
  int           args [0:MAX_LINES-1][0:3];
  int           n_lines;
  logic         loaded;
  logic [31:0]  lfsr;
  luma_t        exp_q [$];       // scoreboard of expected luma
  luma_t        exp_next;        // expected luma of the pixel being driven
  frame_state_e exp_state;       // model of the frame FSM
  int           acc_cnt;
  int           frames_opened;
  int           done_cnt;
  logic         accepted;
  logic         hold_prev;
  logic         prev_yv;
  luma_t        prev_y;
  luma_t        exp_y;
  string        cur_test;

  luma_conv_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .pix_valid  (pix_valid),
    .r          (r),
    .g          (g),
    .b          (b),
    .in_ready   (in_ready),
    .out_ready  (out_ready),
    .y_valid    (y_valid),
    .y          (y),
    .frame_done (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;   // 8 ns period
  end

  // --------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s (%s)", msg, cur_test);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_luma(input string name, input luma_t exp_v, input luma_t act_v);
    if (exp_v !== act_v) begin
      $display("** Error: %s / %s expected %0d actual %0d", cur_test, name, exp_v, act_v);
      $display("Simulation finished: FAIL");
      $fatal(1, "luma mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (exp_v !== act_v) begin
      $display("** Error: %s / %s expected %b actual %b", cur_test, name, exp_v, act_v);
      $display("Simulation finished: FAIL");
      $fatal(1, "flag mismatch");
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  // rounded weighted sum, clamped to 8 bits
  function automatic luma_t luma_ref(input int rv, input int gv, input int bv);
    int s;
    s = (77 * rv + 150 * gv + 29 * bv + 128) >> 8;
    if (s > 255) begin
      s = 255;
    end
    return luma_t'(s);
  endfunction

  // --------------------------------------------------------------------
  // monitor and frame model, sampled on the rising edge
  // --------------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst) begin
      accepted = pix_valid && in_ready && out_ready;
      if (hold_prev) begin                          // previous edge was stalled
        check_flag("y_valid held", prev_yv, y_valid);
        check_luma("y held", prev_y, y);
      end
      if (!y_valid) begin
        check_luma("y zero when not valid", 8'd0, y);
      end
      if (y_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("luma produced with no pixel outstanding");
        end
        exp_y = exp_q.pop_front();
        check_luma("luma", exp_y, y);
      end
      check_flag("in_ready", exp_state == ACTIVE, in_ready);
      if (frame_done) begin
        if (exp_state != DRAIN) begin
          fail_run("frame_done outside the drain of a frame");
        end
        if (exp_q.size() != 0) begin
          fail_run("frame_done before the last luma was consumed");
        end
      end
      case (exp_state)
        IDLE: begin
          if (start) begin
            exp_state     = ACTIVE;
            acc_cnt       = 0;
            frames_opened = frames_opened + 1;
          end
        end
        ACTIVE: begin
          if (accepted) begin
            acc_cnt = acc_cnt + 1;
            if (acc_cnt == FRAME_PIXELS) begin
              exp_state = DRAIN;
            end
          end
        end
        default: begin
          if (frame_done) begin
            exp_state = IDLE;
            done_cnt  = done_cnt + 1;
          end
        end
      endcase
      if (accepted) begin
        exp_q.push_back(exp_next);
      end
    end
    hold_prev = !rst && !out_ready;
    prev_yv   = y_valid;
    prev_y    = y;
  end

  // --------------------------------------------------------------------
  // watchdog, 40 cycles per stim line plus 200
  // --------------------------------------------------------------------
  initial begin
    wait (loaded === 1'b1);
    repeat (n_lines * 40 + 200) @(posedge clk);
    fail_run("watchdog expired, the DUT stopped making progress");
  end

  // --------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------
  task automatic load_stim();
    int    fd;
    int    n;
    string line;
    string opname;
    int    a0;
    int    a1;
    int    a2;
    int    a3;
    fd = $fopen("luma_stim.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open luma_stim.txt");
    end
    n_lines = 0;
    while (!$feof(fd)) begin
      line = "";
      n    = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 0) == "#") begin
        continue;                                   // comment or blank
      end
      a0 = 0;
      a1 = 0;
      a2 = 0;
      a3 = 0;
      n  = $sscanf(line, "%s %d %d %d %d", opname, a0, a1, a2, a3);
      case (opname)
        "START":     ops[n_lines] = START;
        "PIX":       ops[n_lines] = PIX;
        "STALL":     ops[n_lines] = STALL;
        "RAND":      ops[n_lines] = RAND;
        "WAIT_DONE": ops[n_lines] = WAIT_DONE;
        default:     fail_run("unknown opcode in the stimulus file");
      endcase
      args[n_lines][0] = a0;
      args[n_lines][1] = a1;
      args[n_lines][2] = a2;
      args[n_lines][3] = a3;
      n_lines = n_lines + 1;
    end
    $fclose(fd);
  endtask

  // hold one pixel until the DUT takes it
  task automatic send_pixel(input int rv, input int gv, input int bv, input luma_t ev);
    @(negedge clk);
    start     = 1'b0;
    pix_valid = 1'b1;
    r         = pix_t'(rv);
    g         = pix_t'(gv);
    b         = pix_t'(bv);
    exp_next  = ev;
    do begin
      @(posedge clk);
    end while (!(pix_valid && in_ready && out_ready));
  endtask

  initial begin
    int gap;
    int rv;
    int gv;
    int bv;
    int target;
    rst       = 1'b1;
    start     = 1'b0;
    pix_valid = 1'b0;
    r         = '0;
    g         = '0;
    b         = '0;
    out_ready = 1'b1;
    loaded    = 1'b0;
    lfsr      = 32'h66f2f638;
    exp_state = IDLE;
    exp_next  = '0;
    acc_cnt       = 0;
    frames_opened = 0;
    done_cnt      = 0;
    hold_prev     = 1'b0;
    cur_test  = "reset";
    load_stim();
    loaded = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    check_flag("in_ready after reset", 1'b0, in_ready);
    check_flag("y_valid after reset", 1'b0, y_valid);
    check_flag("frame_done after reset", 1'b0, frame_done);
    check_luma("y after reset", 8'd0, y);
    repeat (3) @(negedge clk);                      // in_ready must stay low
    for (int i = 0; i < n_lines; i++) begin
      case (ops[i])
        START: begin
          cur_test = $sformatf("start, line %0d", i);
          @(negedge clk);
          pix_valid = 1'b0;
          start     = 1'b1;
          @(negedge clk);
          start = 1'b0;
        end
        PIX: begin
          cur_test = $sformatf("fixed pixel, line %0d", i);
          send_pixel(args[i][0], args[i][1], args[i][2], luma_t'(args[i][3]));
        end
        STALL: begin
          cur_test = $sformatf("stall, line %0d", i);
          @(negedge clk);
          pix_valid = 1'b0;
          out_ready = 1'b0;
          repeat (args[i][0]) @(negedge clk);
          out_ready = 1'b1;
        end
        RAND: begin
          cur_test = $sformatf("random pixels, line %0d", i);
          for (int k = 0; k < args[i][0]; k++) begin
            gap = rand_bits(2);
            for (int j = 0; j < gap; j++) begin
              @(negedge clk);
              pix_valid = 1'b0;                     // idle slot on the input
            end
            rv = rand_bits(8);
            gv = rand_bits(8);
            bv = rand_bits(8);
            send_pixel(rv, gv, bv, luma_ref(rv, gv, bv));
          end
        end
        default: begin
          cur_test = $sformatf("wait for frame_done, line %0d", i);
          @(negedge clk);
          pix_valid = 1'b0;
          target    = frames_opened;
          while (done_cnt < target) begin
            @(negedge clk);                         // monitor counts on the rising edge
          end
        end
      endcase
    end
    cur_test = "end of run";
    @(negedge clk);
    pix_valid = 1'b0;
    repeat (10) @(negedge clk);
    if (exp_q.size() != 0) begin
      fail_run("luma values still outstanding at the end");
    end else if (done_cnt != frames_opened) begin
      fail_run("frame_done count differs from the number of frames");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- luma_conv_top.sv
// rgb to luma converter, top level
// frame control, pixel counter and the 3-stage luma pipeline
`timescale 1ns/10ps
`default_nettype none

module luma_conv_top import luma_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  start,
  input  logic  pix_valid,
  input  pix_t  r,
  input  pix_t  g,
  input  pix_t  b,
  output logic  in_ready,
  input  logic  out_ready,   // also the pipeline clock enable
  output logic  y_valid,
  output luma_t y,
  output logic  frame_done
);

  // --------------------------------------------------------------------
  // internal nets
  // --------------------------------------------------------------------
  logic  accept;             // v1_valid of the pipeline
  logic  pipe_busy;
  logic  last_pix;
  logic  count_clear;
  logic  v2_valid;
  logic  term_busy;
  term_t r_term;
  term_t g_term;
  term_t b_term;

  assign accept    = pix_valid & in_ready & out_ready;
  assign pipe_busy = term_busy | v2_valid | y_valid;

  // --------------------------------------------------------------------
  // control
  // --------------------------------------------------------------------
  frame_ctrl u_frame_ctrl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .last_pix    (last_pix),
    .accept      (accept),
    .pipe_busy   (pipe_busy),
    .in_ready    (in_ready),
    .count_clear (count_clear),
    .frame_done  (frame_done)
  );

  pixel_counter u_pixel_counter (
    .clk      (clk),
    .rst      (rst),
    .clear    (count_clear),
    .inc      (accept),
    .last_pix (last_pix)
  );

  // --------------------------------------------------------------------
  // datapath
  // --------------------------------------------------------------------
  rgb_term_mul u_term (
    .clk      (clk),
    .rst      (rst),
    .en       (out_ready),
    .v1_valid (accept),
    .r        (r),
    .g        (g),
    .b        (b),
    .v2_valid (v2_valid),
    .r_term   (r_term),
    .g_term   (g_term),
    .b_term   (b_term),
    .busy     (term_busy)
  );

  rgb_sum_acc u_sum (
    .clk      (clk),
    .rst      (rst),
    .en       (out_ready),
    .v2_valid (v2_valid),
    .r_term   (r_term),
    .g_term   (g_term),
    .b_term   (b_term),
    .v3_valid (y_valid),
    .sum      (),            // debug only
    .y_out    (y)
  );

endmodule

`default_nettype wire

//--- frame_ctrl.sv
// frame controller
// opens a frame on start, admits pixels until the last one is taken,
// waits for the pipeline to empty and then pulses frame_done
`timescale 1ns/10ps
`default_nettype none

module frame_ctrl import luma_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,        // one cycle, only seen in IDLE
  input  logic last_pix,     // from pixel_counter
  input  logic accept,       // pixel taken this cycle
  input  logic pipe_busy,    // any stage still holds a pixel
  output logic in_ready,
  output logic count_clear,
  output logic frame_done
);

  frame_state_e state;
  frame_state_e state_nxt;

  // --------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------
  always_comb begin
    state_nxt = state;
    unique case (state)
      IDLE: begin
        if (start) begin
          state_nxt = ACTIVE;
        end
      end
      ACTIVE: begin
        // start is ignored here, only the pixel count ends the frame
        if (accept && last_pix) begin
          state_nxt = DRAIN;
        end
      end
      DRAIN: begin
        if (!pipe_busy) begin
          state_nxt = IDLE;    // last luma consumed
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  // --------------------------------------------------------------------
  // state register
  // --------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // --------------------------------------------------------------------
  // outputs, decoded
  // --------------------------------------------------------------------
  assign in_ready    = (state == ACTIVE);             // drops the cycle after last accept
  assign count_clear = (state == IDLE) && start;
  assign frame_done  = (state == DRAIN) && !pipe_busy;

  // one pulse per frame, and the controller is back in IDLE after it
  a_done_once : assert property (
    @(posedge clk) disable iff (rst)
      frame_done |=> (state == IDLE) && !frame_done
  );

endmodule

`default_nettype wire

//--- pixel_counter.sv
// pixel counter
// counts accepted pixels in a frame, flags the last one and wraps
`timescale 1ns/10ps
`default_nettype none

module pixel_counter import luma_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic clear,     // frame start
  input  logic inc,       // one accepted pixel
  output logic last_pix   // inc at count FRAME_PIXELS-1
);

  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(FRAME_PIXELS - 1);

  logic [CNT_W-1:0] count;

  // --------------------------------------------------------------------
  // last pixel flag, combinational from the strobe
  // --------------------------------------------------------------------
  assign last_pix = inc && (count == CNT_LAST);

  // --------------------------------------------------------------------
  // counter
  // --------------------------------------------------------------------
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;                       // new frame
    end else if (inc) begin
      if (last_pix) begin
        count <= '0;                     // wrap after the final pixel
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  // count stays inside the frame no matter how inc and clear interleave
  a_cnt_range : assert property (
    @(posedge clk) disable iff (rst)
      count <= CNT_LAST
  );

endmodule

`default_nettype wire

//--- rgb_sum_acc.sv
// rgb term accumulator
// adds the three weighted terms to a 17-bit sum, carries it through
// LAT+1 enabled registers and rounds / clamps it to an 8-bit luma
`timescale 1ns/10ps
`default_nettype none

module rgb_sum_acc import luma_pkg::*; #(
  parameter int unsigned LAT = PIPE_LAT     // 1 .. 3
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  en,          // advance, 0 = hold every register
  input  logic  v2_valid,
  input  term_t r_term,
  input  term_t g_term,
  input  term_t b_term,
  output logic  v3_valid,
  output sum_t  sum,         // debug copy of the last sum register
  output luma_t y_out
);

  // --------------------------------------------------------------------
  // combinational add
  // --------------------------------------------------------------------
  sum_t sum0;

  always_comb begin
    // widen first so the carry into bit 16 is kept
    sum0 = sum_t'(r_term) + sum_t'(g_term) + sum_t'(b_term);
  end

  // --------------------------------------------------------------------
  // sum pipeline
  // --------------------------------------------------------------------
  logic [LAT:0] v_sh;          // valid per slot
  sum_t         s_pipe [0:LAT];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v_sh <= '0;
      for (int k = 0; k <= LAT; k++) begin
        s_pipe[k] <= '0;
      end
    end else if (en) begin
      v_sh[0]   <= v2_valid;
      s_pipe[0] <= v2_valid ? sum0 : '0;   // invalid slots hold zero
      for (int k = 1; k <= LAT; k++) begin
        v_sh[k]   <= v_sh[k-1];
        s_pipe[k] <= s_pipe[k-1];
      end
    end
    // en low: everything holds, output stays stable
  end

  assign v3_valid = v_sh[LAT];
  assign sum      = s_pipe[LAT];

  // --------------------------------------------------------------------
  // round, shift, clamp
  // --------------------------------------------------------------------
  logic [SUM_W:0] s_bias;      // one extra bit for the bias carry
  logic [SUM_W:0] s_shift;

  always_comb begin
    s_bias  = {1'b0, s_pipe[LAT]} + (SUM_W+1)'(Y_BIAS);
    s_shift = s_bias >> Y_SHIFT;
    if (s_shift > (SUM_W+1)'(255)) begin
      y_out = 8'hff;             // saturate to white
    end else begin
      y_out = luma_t'(s_shift);
    end
  end

  // --------------------------------------------------------------------
  // checks
  // --------------------------------------------------------------------
  // 8-bit inputs from the term stage can never push the sum past SUM_MAX
  a_sum_range : assert property (
    @(posedge clk) disable iff (rst)
      v2_valid |-> (sum0 <= SUM_MAX)
  );

  // held output while the downstream side stalls
  a_valid_hold : assert property (
    @(posedge clk) disable iff (rst)
      !en |=> $stable(v3_valid)
  );

endmodule

`default_nettype wire

//--- rgb_term_mul.sv
// rgb weighted term stage
// registers r*W_R, g*W_G and b*W_B under the pipeline enable and
// tracks how far the pixels are still in flight for drain detection
`timescale 1ns/10ps
`default_nettype none

module rgb_term_mul import luma_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  en,        // pipeline advance, 0 = hold
  input  logic  v1_valid,  // accepted pixel
  input  pix_t  r,
  input  pix_t  g,
  input  pix_t  b,
  output logic  v2_valid,
  output term_t r_term,
  output term_t g_term,
  output term_t b_term,
  output logic  busy       // a pixel from this stage is not yet at the sum output
);

  // --------------------------------------------------------------------
  // valid history
  // --------------------------------------------------------------------
  // v_hist[0] is this stage's valid register; the upper bits shadow
  // the same pixels through the hidden sum registers of the next stage
  logic [PIPE_LAT:0] v_hist;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      v_hist <= '0;
    end else if (en) begin
      v_hist <= {v_hist[PIPE_LAT-1:0], v1_valid};  // shift in the new pixel
    end
  end

  assign v2_valid = v_hist[0];
  assign busy     = |v_hist;   // also covers the inner sum regs, y_valid covers the last one

  // --------------------------------------------------------------------
  // weighted terms, payload only
  // --------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (en) begin
      if (v1_valid) begin
        r_term <= term_t'(r * W_R);   // max 19635
        g_term <= term_t'(g * W_G);   // max 38250
        b_term <= term_t'(b * W_B);   // max 7395
      end else begin
        r_term <= '0;                 // empty slot carries zero
        g_term <= '0;
        b_term <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- luma_pkg.sv
// luma conversion package
// shared weights, rounding constants, frame size, data types and FSM states
`default_nettype none

package luma_pkg;

  // --------------------------------------------------------------------
  // BT.601 style luma weights, scaled by 256
  // --------------------------------------------------------------------
  localparam int W_R = 77;
  localparam int W_G = 150;
  localparam int W_B = 29;                      // 77 + 150 + 29 = 256

  // --------------------------------------------------------------------
  // sum and rounding
  // --------------------------------------------------------------------
  localparam int          SUM_W   = 17;         // 255*256 needs 16 bits, one spare
  localparam logic [16:0] SUM_MAX = 17'd65280;  // all components at 255
  localparam int          Y_SHIFT = 8;          // divide by weight total
  localparam int          Y_BIAS  = 128;        // half lsb after the shift

  // --------------------------------------------------------------------
  // frame and pipeline
  // --------------------------------------------------------------------
  localparam int FRAME_PIXELS = 16;
  localparam int CNT_W        = 5;              // holds 0 .. FRAME_PIXELS-1
  localparam int PIPE_LAT     = 1;              // extra sum regs, LAT+1 total

  // data types
  typedef logic [7:0]       pix_t;              // one colour component
  typedef logic [15:0]      term_t;             // component times weight
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [7:0]       luma_t;

  // frame controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    ACTIVE = 2'd1,
    DRAIN  = 2'd2
  } frame_state_e;

endpackage

`default_nettype wire
